// File: dcache_cases.txt
// op_addr_byteen_wrdata_exprd_expmiss_wbaddr, one case per line
// op 0 read, 1 write; wbaddr ffffffff when no write-back is expected
0_00000110_0_00000000_c0de0110_1_ffffffff
0_0000011c_0_00000000_c0de011c_0_ffffffff
1_00000114_3_aabbccdd_00000000_0_ffffffff
0_00000114_0_00000000_c0deccdd_0_ffffffff
1_00001118_f_11112222_00000000_1_ffffffff
0_00002110_0_00000000_c0de2110_1_00000110
0_00000114_0_00000000_c0deccdd_1_00001110
0_00001118_0_00000000_11112222_1_ffffffff
1_00000124_c_55667788_00000000_1_ffffffff
0_00000124_0_00000000_55660124_0_ffffffff
1_00000128_4_00ab0000_00000000_0_ffffffff
0_00003120_0_00000000_c0de3120_1_ffffffff
0_00004124_0_00000000_c0de4124_1_00000120
0_0000012c_0_00000000_c0de012c_1_ffffffff
0_00000128_0_00000000_c0ab0128_0_ffffffff
0_00000110_0_00000000_c0de0110_0_ffffffff
1_00000110_8_ee000000_00000000_0_ffffffff
0_00002114_0_00000000_c0de2114_1_ffffffff
0_0000111c_0_00000000_c0de111c_1_00000110
0_00000110_0_00000000_eede0110_1_ffffffff

// File: dcache.f
dcache_pkg.sv
tag_port_if.sv
data_port_if.sv
cache_ctrl.sv
tag_store.sv
data_store.sv
victim_select.sv
dcache.sv
tb_clock.sv
tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f dcache.f -o Vtb_dcache

output=$(./obj_dir/Vtb_dcache) || { echo "$output"; exit 1; }
echo "$output"

if grep -qx '>>> PASS' <<< "$output"; then
    exit 0
fi
exit 1

// File: tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    logic     clk;
    logic     rst;
    addr_t    addr;
    logic     rd_req;
    logic     wr_req;
    word_t    wr_data;
    byte_en_t byte_en;
    word_t    rd_data;
    logic     miss;
    addr_t    mem_addr;
    logic     mem_rd_req;
    line_t    mem_rd_data;
    logic     mem_wr_req;
    line_t    mem_wr_data;
    logic     mem_gnt;

    // op | addr | byte_en | wr_data | exp_rd | exp_miss | wb_addr
    logic [139:0] cases [64];
    int           n_cases;
    logic         loaded = 1'b0;
    int           errors;
    integer       seed;

    logic [7:0] shadow [addr_t];
    word_t      mem_model [addr_t];

    // memory traffic seen during the current case
    int    rd_grants;
    int    wr_grants;
    addr_t wb_addr;
    addr_t cur_addr;

    tb_clock clock_gen (.clk(clk));

    dcache dcache_inst (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .rd_req      (rd_req),
        .wr_req      (wr_req),
        .wr_data     (wr_data),
        .byte_en     (byte_en),
        .rd_data     (rd_data),
        .miss        (miss),
        .mem_addr    (mem_addr),
        .mem_rd_req  (mem_rd_req),
        .mem_rd_data (mem_rd_data),
        .mem_wr_req  (mem_wr_req),
        .mem_wr_data (mem_wr_data),
        .mem_gnt     (mem_gnt)
    );

    // untouched memory holds its own address xor a marker
    function automatic word_t model_word(addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return a ^ 32'hc0de_0000;
    endfunction

    // written bytes come from the shadow and the rest from the memory rule
    function automatic word_t expected_word(addr_t a);
        word_t w;
        word_t rule;
        addr_t base;
        base = {a[31:2], 2'b00};
        rule = base ^ 32'hc0de_0000;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = shadow.exists(base + i) ? shadow[base + i] : rule[8*i +: 8];
        end
        return w;
    endfunction

    initial begin : memory_model
        int    delay;
        addr_t req_addr;
        mem_gnt     = 1'b0;
        mem_rd_data = '0;
        @(posedge clk);
        #2;
        forever begin
            if (!rst && (mem_rd_req || mem_wr_req)) begin
                req_addr = mem_addr;
                delay    = $random(seed) & 7;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                    if (!(mem_rd_req || mem_wr_req) || mem_addr !== req_addr || !miss) begin
                        $display("memory request at %h dropped or changed before grant",
                                 req_addr);
                        errors++;
                    end
                end
                if (req_addr[3:0] != 4'h0) begin
                    $display("memory address %h is not line aligned", req_addr);
                    errors++;
                end
                if (mem_wr_req) begin
                    wr_grants++;
                    wb_addr = req_addr;
                    for (int i = 0; i < 4; i++) begin
                        if (mem_wr_data[32*i +: 32] !== expected_word(req_addr + 4*i)) begin
                            $display("Mismatch mem_wr_data word %0d: got %h expected %h", i,
                                     mem_wr_data[32*i +: 32], expected_word(req_addr + 4*i));
                            errors++;
                        end
                        mem_model[req_addr + 4*i] = mem_wr_data[32*i +: 32];
                    end
                end else begin
                    rd_grants++;
                    if (req_addr !== {cur_addr[31:4], 4'h0}) begin
                        $display("Mismatch mem_addr: got %h expected %h", req_addr,
                                 {cur_addr[31:4], 4'h0});
                        errors++;
                    end
                    for (int i = 0; i < 4; i++) begin
                        mem_rd_data[32*i +: 32] = model_word(req_addr + 4*i);
                    end
                end
                mem_gnt = 1'b1;
                @(posedge clk);
                #2;
                mem_gnt     = 1'b0;
                mem_rd_data = '0;
            end else begin
                @(posedge clk);
                #2;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        #((n_cases + 1) * 40 * 40);
        $display("timeout: cases did not finish within %0d cycles each", 40);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [139:0] c;
        logic [3:0]   op;
        logic         saw_miss;
        int           first_err;
        int           cycles;
        int           passed;
        int           failed;
        seed      = 32'h79b9_f868;
        rst       = 1'b1;
        addr      = '0;
        rd_req    = 1'b0;
        wr_req    = 1'b0;
        wr_data   = '0;
        byte_en   = '0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        rd_grants = 0;
        wr_grants = 0;
        wb_addr   = '1;
        cur_addr  = '0;
        for (int i = 0; i < 64; i++) begin
            cases[i] = '1;
        end
        $readmemh("dcache_cases.txt", cases);
        n_cases = 0;
        while (n_cases < 64 && cases[n_cases][139:136] != 4'hf) begin
            n_cases++;
        end
        loaded = 1'b1;
        if (n_cases == 0) begin
            $display("no cases read from dcache_cases.txt");
            errors++;
        end

        // miss forced high and memory quiet during reset
        repeat (5) begin
            @(posedge clk);
            #2;
            if (miss !== 1'b1 || mem_rd_req !== 1'b0 || mem_wr_req !== 1'b0) begin
                $display("miss low or a memory request high during reset");
                errors++;
            end
        end
        rst = 1'b0;
        if (errors == 0) begin
            $display("reset: ok");
        end else begin
            $display("reset: failed");
        end

        for (int k = 0; k < n_cases; k++) begin
            c         = cases[k];
            op        = c[139:136];
            first_err = errors;
            rd_grants = 0;
            wr_grants = 0;
            wb_addr   = '1;
            cur_addr  = c[135:104];
            addr      = c[135:104];
            byte_en   = c[103:100];
            wr_data   = c[99:68];
            rd_req    = (op == 4'h0);
            wr_req    = (op == 4'h1);
            @(negedge clk);
            saw_miss = miss;
            cycles   = 0;
            while (miss && cycles < 40) begin
                @(negedge clk);
                cycles++;
            end
            if (miss) begin
                $display("case %0d: miss did not clear within 40 cycles", k);
                errors++;
            end
            if (saw_miss !== c[32]) begin
                $display("Mismatch miss: got %h expected %h", saw_miss, c[32]);
                errors++;
            end
            if (rd_grants != (c[32] ? 1 : 0)) begin
                $display("case %0d: %0d refills seen, expected %0d", k, rd_grants,
                         c[32] ? 1 : 0);
                errors++;
            end
            if (c[31:0] == 32'hffff_ffff) begin
                if (wr_grants != 0) begin
                    $display("case %0d: unexpected write-back of line %h", k, wb_addr);
                    errors++;
                end
            end else if (wr_grants != 1) begin
                $display("case %0d: expected one write-back, saw %0d", k, wr_grants);
                errors++;
            end else if (wb_addr !== c[31:0]) begin
                $display("Mismatch mem_addr: got %h expected %h", wb_addr, c[31:0]);
                errors++;
            end
            if (op == 4'h0) begin
                if (rd_data !== c[67:36]) begin
                    $display("Mismatch rd_data: got %h expected %h", rd_data, c[67:36]);
                    errors++;
                end
                if (rd_data !== expected_word(addr)) begin
                    $display("Mismatch rd_data: got %h shadow %h", rd_data, expected_word(addr));
                    errors++;
                end
            end
            @(posedge clk);
            #2;
            // write hit lands at the edge just passed
            if (op == 4'h1) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) begin
                        shadow[{addr[31:2], 2'b00} + b] = wr_data[8*b +: 8];
                    end
                end
            end
            if (errors == first_err) begin
                passed++;
                $display("case %0d op %0d addr %h: ok", k, op, addr);
            end else begin
                failed++;
                $display("case %0d op %0d addr %h: failed", k, op, addr);
            end
        end
        rd_req = 1'b0;
        wr_req = 1'b0;

        $display("cases %0d, passed %0d, failed %0d, errors %0d", n_cases, passed, failed,
                 errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule

// File: dcache.sv
`timescale 1ns/1ps

module dcache import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  addr_t    addr,
    input  logic     rd_req,
    input  logic     wr_req,
    input  word_t    wr_data,
    input  byte_en_t byte_en,
    output word_t    rd_data,
    output logic     miss,
    output addr_t    mem_addr,
    output logic     mem_rd_req,
    input  line_t    mem_rd_data,
    output logic     mem_wr_req,
    output line_t    mem_wr_data,
    input  logic     mem_gnt
);

    tag_port_if  tags_if ();
    data_port_if data_if ();

    way_t victim_way;
    logic req_hit;

    // only a real request moves the replacement pointer
    assign req_hit = (rd_req | wr_req) & tags_if.hit;
    assign rd_data = data_if.rd_word;

    cache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .rd_req      (rd_req),
        .wr_req      (wr_req),
        .addr        (addr),
        .wr_data     (wr_data),
        .byte_en     (byte_en),
        .victim_way  (victim_way),
        .tags        (tags_if.ctrl),
        .data        (data_if.ctrl),
        .miss        (miss),
        .mem_addr    (mem_addr),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_wr_data (mem_wr_data),
        .mem_rd_data (mem_rd_data),
        .mem_gnt     (mem_gnt)
    );

    tag_store u_tags (
        .clk        (clk),
        .rst        (rst),
        .victim_way (victim_way),
        .port       (tags_if.store)
    );

    data_store u_data (
        .clk        (clk),
        .victim_way (victim_way),
        .port       (data_if.store)
    );

    victim_select u_victim (
        .clk        (clk),
        .rst        (rst),
        .set        (tags_if.set),
        .hit        (req_hit),
        .hit_way    (tags_if.hit_way),
        .victim_way (victim_way)
    );

endmodule

// File: victim_select.sv
`timescale 1ns/1ps

module victim_select import dcache_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  set_t set,
    input  logic hit,
    input  way_t hit_way,
    output way_t victim_way
);

    way_t [NUM_SETS-1:0] ptr_q;

    assign victim_way = ptr_q[set];

    // step past a way once it has been used
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (hit && hit_way == ptr_q[set]) begin
            ptr_q[set] <= way_t'(ptr_q[set] + 1'b1);
        end
    end

endmodule

// File: data_store.sv
`timescale 1ns/1ps

module data_store import dcache_pkg::*; (
    input  logic        clk,
    input  way_t        victim_way,
    data_port_if.store  port
);

    word_t mem_q [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];
    word_t old_word;
    word_t merged_word;

    assign old_word     = mem_q[port.access_way][port.set][port.word_sel];
    assign port.rd_word = old_word;

    // keep disabled lanes from the stored word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[8*b +: 8] = port.byte_en[b] ? port.wr_word[8*b +: 8] : old_word[8*b +: 8];
        end
    end

    always_comb begin
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            port.victim_line[32*i +: 32] = mem_q[victim_way][port.set][i];
        end
    end

    always_ff @(posedge clk) begin
        if (port.fill_en) begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                mem_q[port.access_way][port.set][i] <= port.fill_line[32*i +: 32];
            end
        end else if (port.word_we) begin
            mem_q[port.access_way][port.set][port.word_sel] <= merged_word;
        end
    end

    // the controller never fills while a write hit is in progress
    no_we_during_fill: assert property (@(posedge clk) !(port.word_we && port.fill_en));

endmodule

// File: tag_store.sv
`timescale 1ns/1ps

module tag_store import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  way_t       victim_way,
    tag_port_if.store  port
);

    tag_t                               tag_q [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_WAYS-1:0]               way_hit;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w][port.set] && (tag_q[w][port.set] == port.lookup_tag);
        end
    end

    assign port.hit     = |way_hit;
    assign port.hit_way = way_t'(way_hit[1]);

    // state of the line the selector would replace
    assign port.victim_valid = valid_q[victim_way][port.set];
    assign port.victim_dirty = dirty_q[victim_way][port.set];
    assign port.victim_tag   = tag_q[victim_way][port.set];

    always_ff @(posedge clk) begin
        if (port.upd_en) begin
            tag_q[port.upd_way][port.set] <= port.lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (port.upd_en) begin
            valid_q[port.upd_way][port.set] <= port.upd_valid;
            dirty_q[port.upd_way][port.set] <= port.upd_dirty;
        end
    end

    // a tag is never filled into both ways of one set
    one_way_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule

// File: cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import dcache_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     rd_req,
    input  logic     wr_req,
    input  addr_t    addr,
    input  word_t    wr_data,
    input  byte_en_t byte_en,
    input  way_t     victim_way,
    tag_port_if.ctrl  tags,
    data_port_if.ctrl data,
    output logic     miss,
    output addr_t    mem_addr,
    output logic     mem_rd_req,
    output logic     mem_wr_req,
    output line_t    mem_wr_data,
    input  line_t    mem_rd_data,
    input  logic     mem_gnt
);

    cache_state_t state, state_next;
    tag_t         req_tag;
    set_t         req_set;
    word_sel_t    req_word;
    logic         req;
    logic         wr_hit;
    line_t        fill_buf;

    assign req_tag  = addr[31 -: TAG_W];
    assign req_set  = addr[31-TAG_W -: SET_W];
    assign req_word = addr[31-TAG_W-SET_W -: WORD_SEL_W];
    assign req      = rd_req | wr_req;

    // write hits only complete while idle
    assign wr_hit = (state == IDLE) & wr_req & tags.hit;
    assign miss   = rst | (req & ~tags.hit) | (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (req && !tags.hit) begin
                    state_next = (tags.victim_valid && tags.victim_dirty) ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: if (mem_gnt) state_next = REFILL;
            REFILL:    if (mem_gnt) state_next = FILL;
            FILL:      state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    // refill line is only valid in the grant cycle
    always_ff @(posedge clk) begin
        if (state == REFILL && mem_gnt) begin
            fill_buf <= mem_rd_data;
        end
    end

    // line aligned victim or refill address
    assign mem_addr    = (state == WRITEBACK) ?
                         {tags.victim_tag, req_set, {(32 - TAG_W - SET_W){1'b0}}} :
                         {req_tag, req_set, {(32 - TAG_W - SET_W){1'b0}}};
    assign mem_wr_req  = (state == WRITEBACK);
    assign mem_rd_req  = (state == REFILL);
    assign mem_wr_data = data.victim_line;

    assign tags.set        = req_set;
    assign tags.lookup_tag = req_tag;
    assign tags.upd_en     = wr_hit | (state == FILL);
    assign tags.upd_way    = (state == FILL) ? victim_way : tags.hit_way;
    assign tags.upd_valid  = 1'b1;
    assign tags.upd_dirty  = wr_hit;

    assign data.set        = req_set;
    assign data.word_sel   = req_word;
    assign data.access_way = (state == FILL) ? victim_way : tags.hit_way;
    assign data.word_we    = wr_hit;
    assign data.byte_en    = byte_en;
    assign data.wr_word    = wr_data;
    assign data.fill_en    = (state == FILL);
    assign data.fill_line  = fill_buf;

    cpu_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req));

    // memory requests hold until granted
    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_rd_req || mem_wr_req) && !mem_gnt |=> $stable(mem_addr) && (mem_rd_req || mem_wr_req));

endmodule

// File: data_port_if.sv
`timescale 1ns/1ps

interface data_port_if import dcache_pkg::*; ();

    // word access and line fill, from the controller
    set_t      set;
    word_sel_t word_sel;
    way_t      access_way;
    logic      word_we;
    byte_en_t  byte_en;
    word_t     wr_word;
    logic      fill_en;
    line_t     fill_line;

    // read side, from the data store
    word_t rd_word;
    line_t victim_line;

    modport ctrl (
        output set, word_sel, access_way, word_we, byte_en, wr_word, fill_en, fill_line,
        input  rd_word, victim_line
    );

    modport store (
        input  set, word_sel, access_way, word_we, byte_en, wr_word, fill_en, fill_line,
        output rd_word, victim_line
    );

endinterface

// File: tag_port_if.sv
`timescale 1ns/1ps

interface tag_port_if import dcache_pkg::*; ();

    // lookup and update, from the controller
    set_t set;
    tag_t lookup_tag;
    logic upd_en;
    way_t upd_way;
    logic upd_valid;
    logic upd_dirty;

    // compare result and victim state, from the tag store
    logic hit;
    way_t hit_way;
    logic victim_valid;
    logic victim_dirty;
    tag_t victim_tag;

    modport ctrl (
        output set, lookup_tag, upd_en, upd_way, upd_valid, upd_dirty,
        input  hit, hit_way, victim_valid, victim_dirty, victim_tag
    );

    modport store (
        input  set, lookup_tag, upd_en, upd_way, upd_valid, upd_dirty,
        output hit, hit_way, victim_valid, victim_dirty, victim_tag
    );

endinterface

// File: dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 16;
    localparam int WORDS_PER_LINE = 4;

    // address split: tag | set | word | byte
    localparam int TAG_W      = 24;
    localparam int SET_W      = 4;
    localparam int WORD_SEL_W = 2;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SET_W-1:0]      set_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic                  way_t;
    typedef logic [3:0]            byte_en_t;

    // miss handling sequence
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        REFILL,
        FILL
    } cache_state_t;

endpackage
